// ==== common/rob_expt_cfg.svh ====
// Width settings for the exception entry datapath, included by the package and the RTU modules
`ifndef ROB_EXPT_CFG_SVH
`define ROB_EXPT_CFG_SVH

// --------------------------------------------------------------------------
// Instruction ID
// --------------------------------------------------------------------------
// MSB is the wrap flag, low bits index the ROB
`define ROB_IID_W 7

// --------------------------------------------------------------------------
// Exception payload
// --------------------------------------------------------------------------
// Exception vector as seen at retire
`define ROB_EXPT_VEC_W 14

// Trap value, full XLEN
// pipe0 only fills the low 32 bits of it
`define ROB_MTVAL_W 64

`endif

// ==== common/rob_expt_pkg.sv ====
// Shared types and the iid age rule for the ROB exception entry and split spec fail tracker
`default_nettype none

`include "rob_expt_cfg.svh"

package rob_expt_pkg;

  // Completion payload, common superset of all pipes
  typedef struct packed {
    logic [`ROB_IID_W-1:0]      iid;
    logic                       expt_vld;
    logic [`ROB_EXPT_VEC_W-1:0] expt_vec;
    logic [`ROB_MTVAL_W-1:0]    mtval;
    logic                       flush;
    logic                       spec_fail;
    logic                       bkpt;
    logic                       jmp_mispred;
    logic                       bht_mispred;
  } cmplt_info_t;

  // One completion port
  // Transfer happens when cmplt and abnormal are both high
  typedef struct packed {
    logic        cmplt;
    logic        abnormal;
    cmplt_info_t info;
  } cmplt_req_t;

  // Fields shown on the retire slot
  typedef struct packed {
    logic                       expt_vld;
    logic [`ROB_EXPT_VEC_W-1:0] expt_vec;
    logic [`ROB_MTVAL_W-1:0]    mtval;
    logic                       inst_flush;
    logic                       jmp_mispred;
    logic                       bht_mispred;
    logic                       bkpt;
    logic                       spec_fail;
    logic                       spec_fail_ssf;
    logic                       spec_fail_no_ssf;
  } retire_info_t;

  // Split spec fail report from an LSU pipe
  typedef struct packed {
    logic                  valid;
    logic [`ROB_IID_W-1:0] iid;
  } ssf_req_t;

  // Bit 1 set means not idle, bit 0 set means retiring
  typedef enum logic [1:0] {
    IDLE      = 2'b00,
    WF_RETIRE = 2'b10,
    RETIRING  = 2'b11
  } ssf_state_t;

  // Age compare across the wrap flag
  // returns 1 when iid_a is older than iid_b
  function automatic logic iid_older(
    input logic [`ROB_IID_W-1:0] iid_a,
    input logic [`ROB_IID_W-1:0] iid_b
  );
    logic same_wrap;
    same_wrap = (iid_a[`ROB_IID_W-1] == iid_b[`ROB_IID_W-1]);
    // Same lap, smaller index is older
    if (same_wrap)
      return iid_a[`ROB_IID_W-2:0] < iid_b[`ROB_IID_W-2:0];
    // Different lap, the one left behind has the larger index
    return iid_a[`ROB_IID_W-2:0] > iid_b[`ROB_IID_W-2:0];
  endfunction

endpackage

`default_nettype wire

// ==== hdl/expt_entry.sv ====
// Single oldest-exception entry; registers the winning completion and drives retire exception fields
`timescale 1ns/1ns
`default_nettype none

module expt_entry (
  input  logic                       entry_clk,
  input  logic                       cpurst_b,
  input  logic                       flush,
  input  logic                       expt_cmplt,
  input  logic [4:0]                 write_sel,
  input  rob_expt_pkg::cmplt_info_t  entry_updt,
  input  logic                       retire_vld,
  input  logic                       retire_abnormal,
  input  logic                       split_spec_fail_flush,
  output logic                       entry_vld,
  output rob_expt_pkg::cmplt_info_t  entry_info,
  output rob_expt_pkg::retire_info_t retire_info
);

  // A pipe won the select, not the held entry
  logic info_load;

  assign info_load = |write_sel[4:1];

  // --------------------------------------------------------------------------
  // Entry valid
  // --------------------------------------------------------------------------
  // Flush first, then new completion, then abnormal retire
  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      entry_vld <= 1'b0;
    else if (flush)
      entry_vld <= 1'b0;
    else if (expt_cmplt)
      entry_vld <= 1'b1;
    else if (retire_vld && retire_abnormal)
      entry_vld <= 1'b0;
  end

  // --------------------------------------------------------------------------
  // Entry payload
  // --------------------------------------------------------------------------
  // Only replaced by an older pipe completion
  always_ff @(posedge entry_clk)
  begin
    if (info_load)
      entry_info <= entry_updt;
  end

  // --------------------------------------------------------------------------
  // Retire view
  // --------------------------------------------------------------------------
  always_comb
  begin
    retire_info.expt_vld    = retire_abnormal && entry_info.expt_vld;
    retire_info.jmp_mispred = retire_abnormal && entry_info.jmp_mispred;
    retire_info.bht_mispred = retire_abnormal && entry_info.bht_mispred;
    retire_info.bkpt        = retire_abnormal && entry_info.bkpt;
    // Raw payload, consumer qualifies with expt_vld
    retire_info.expt_vec    = entry_info.expt_vec;
    retire_info.mtval       = entry_info.mtval;
    // Flush-only completion, or split spec fail on a normal retire
    retire_info.inst_flush  = (retire_abnormal && !entry_info.expt_vld && entry_info.flush)
                              || (!retire_abnormal && split_spec_fail_flush);
    // Two spec fail sources, kept apart for the flush unit
    retire_info.spec_fail_ssf    = !retire_abnormal && split_spec_fail_flush;
    retire_info.spec_fail_no_ssf = retire_abnormal && entry_info.spec_fail;
    retire_info.spec_fail        = retire_info.spec_fail_ssf
                                   || retire_info.spec_fail_no_ssf;
  end

endmodule

`default_nettype wire

// ==== hdl/expt_oldest_select.sv ====
// Picks the oldest abnormal completion among pipe0/2/3/4 and the held entry for the expt entry write
`timescale 1ns/1ns
`default_nettype none

`include "rob_expt_cfg.svh"

module expt_oldest_select (
  input  rob_expt_pkg::cmplt_req_t  pipe0,
  input  rob_expt_pkg::cmplt_req_t  pipe2,
  input  rob_expt_pkg::cmplt_req_t  pipe3,
  input  rob_expt_pkg::cmplt_req_t  pipe4,
  input  logic                      entry_vld,
  input  logic [`ROB_IID_W-1:0]     entry_iid,
  output logic [4:0]                write_sel,
  output rob_expt_pkg::cmplt_info_t entry_updt,
  output logic                      expt_cmplt
);

  // Abnormal completions
  logic pipe0_vld;
  logic pipe2_vld;
  logic pipe3_vld;
  logic pipe4_vld;

  // Pairwise age, name reads "a older than b"
  logic p4_older_p3;
  logic p4_older_p2;
  logic p4_older_p0;
  logic p4_older_e;
  logic p3_older_p2;
  logic p3_older_p0;
  logic p3_older_e;
  logic p2_older_p0;
  logic p2_older_e;
  logic p0_older_e;

  assign pipe0_vld = pipe0.cmplt && pipe0.abnormal;
  assign pipe2_vld = pipe2.cmplt && pipe2.abnormal;
  assign pipe3_vld = pipe3.cmplt && pipe3.abnormal;
  assign pipe4_vld = pipe4.cmplt && pipe4.abnormal;

  assign expt_cmplt = pipe0_vld || pipe2_vld || pipe3_vld || pipe4_vld;

  // --------------------------------------------------------------------------
  // Age compare
  // --------------------------------------------------------------------------
  assign p4_older_p3 = rob_expt_pkg::iid_older(pipe4.info.iid, pipe3.info.iid);
  assign p4_older_p2 = rob_expt_pkg::iid_older(pipe4.info.iid, pipe2.info.iid);
  assign p4_older_p0 = rob_expt_pkg::iid_older(pipe4.info.iid, pipe0.info.iid);
  assign p4_older_e  = rob_expt_pkg::iid_older(pipe4.info.iid, entry_iid);
  assign p3_older_p2 = rob_expt_pkg::iid_older(pipe3.info.iid, pipe2.info.iid);
  assign p3_older_p0 = rob_expt_pkg::iid_older(pipe3.info.iid, pipe0.info.iid);
  assign p3_older_e  = rob_expt_pkg::iid_older(pipe3.info.iid, entry_iid);
  assign p2_older_p0 = rob_expt_pkg::iid_older(pipe2.info.iid, pipe0.info.iid);
  assign p2_older_e  = rob_expt_pkg::iid_older(pipe2.info.iid, entry_iid);
  assign p0_older_e  = rob_expt_pkg::iid_older(pipe0.info.iid, entry_iid);

  // --------------------------------------------------------------------------
  // One-hot select
  // --------------------------------------------------------------------------
  // Source wins when older than every other valid source
  assign write_sel[4] = pipe4_vld && (!pipe3_vld || p4_older_p3)
                        && (!pipe2_vld || p4_older_p2) && (!pipe0_vld || p4_older_p0)
                        && (!entry_vld || p4_older_e);
  assign write_sel[3] = pipe3_vld && (!pipe4_vld || !p4_older_p3)
                        && (!pipe2_vld || p3_older_p2) && (!pipe0_vld || p3_older_p0)
                        && (!entry_vld || p3_older_e);
  assign write_sel[2] = pipe2_vld && (!pipe4_vld || !p4_older_p2)
                        && (!pipe3_vld || !p3_older_p2) && (!pipe0_vld || p2_older_p0)
                        && (!entry_vld || p2_older_e);
  assign write_sel[1] = pipe0_vld && (!pipe4_vld || !p4_older_p0)
                        && (!pipe3_vld || !p3_older_p0) && (!pipe2_vld || !p2_older_p0)
                        && (!entry_vld || p0_older_e);
  // Held entry kept when nothing valid is older
  assign write_sel[0] = entry_vld && (!pipe4_vld || !p4_older_e)
                        && (!pipe3_vld || !p3_older_e) && (!pipe2_vld || !p2_older_e)
                        && (!pipe0_vld || !p0_older_e);

  // Winning pipe payload, zero when the held entry stays
  always_comb
  begin
    case (write_sel)
      5'b10000: entry_updt = pipe4.info;
      5'b01000: entry_updt = pipe3.info;
      5'b00100: entry_updt = pipe2.info;
      5'b00010: entry_updt = pipe0.info;
      default:  entry_updt = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/rob_expt_top.sv ====
// ROB retire exception block top; trims pipe ports and connects select, entry and split spec fail FSM
`timescale 1ns/1ns
`default_nettype none

`include "rob_expt_cfg.svh"

module rob_expt_top (
  input  logic                       entry_clk,
  input  logic                       cpurst_b,
  input  rob_expt_pkg::cmplt_req_t   pipe0_cmplt,
  input  rob_expt_pkg::cmplt_req_t   pipe2_cmplt,
  input  rob_expt_pkg::cmplt_req_t   pipe3_cmplt,
  input  rob_expt_pkg::cmplt_req_t   pipe4_cmplt,
  input  rob_expt_pkg::ssf_req_t     pipe3_ssf,
  input  rob_expt_pkg::ssf_req_t     pipe4_ssf,
  input  logic                       retire_vld,
  input  logic                       retire_abnormal,
  input  logic [`ROB_IID_W-1:0]      retire_iid,
  input  logic                       retire_split,
  input  logic                       flush,
  output rob_expt_pkg::retire_info_t retire_info,
  output logic                       expt_entry_vld,
  output logic [`ROB_IID_W-1:0]      expt_entry_iid,
  output logic                       split_spec_fail_srt,
  output logic [`ROB_IID_W-1:0]      ssf_iid,
  output rob_expt_pkg::ssf_state_t   ssf_state
);

  // --------------------------------------------------------------------------
  // Port trimming
  // --------------------------------------------------------------------------
  // pipe0: 5-bit vector, 32-bit mtval, flush and bkpt
  localparam rob_expt_pkg::cmplt_req_t PIPE0_KEEP = '{
    cmplt: 1'b1, abnormal: 1'b1,
    info: '{iid: {`ROB_IID_W{1'b1}}, expt_vld: 1'b1,
            expt_vec: {{(`ROB_EXPT_VEC_W-5){1'b0}}, 5'h1f},
            mtval: {{(`ROB_MTVAL_W-32){1'b0}}, 32'hffff_ffff},
            flush: 1'b1, bkpt: 1'b1, default: '0}};
  // branch pipe, mispredicts only
  localparam rob_expt_pkg::cmplt_req_t PIPE2_KEEP = '{
    cmplt: 1'b1, abnormal: 1'b1,
    info: '{iid: {`ROB_IID_W{1'b1}}, jmp_mispred: 1'b1, bht_mispred: 1'b1, default: '0}};
  // LSU pipes, full exception fields plus spec fail
  localparam rob_expt_pkg::cmplt_req_t LSU_KEEP = '{
    cmplt: 1'b1, abnormal: 1'b1,
    info: '{iid: {`ROB_IID_W{1'b1}}, expt_vld: 1'b1, expt_vec: {`ROB_EXPT_VEC_W{1'b1}},
            mtval: {`ROB_MTVAL_W{1'b1}}, flush: 1'b1, spec_fail: 1'b1, default: '0}};

  rob_expt_pkg::cmplt_req_t  pipe0_req;
  rob_expt_pkg::cmplt_req_t  pipe2_req;
  rob_expt_pkg::cmplt_req_t  pipe3_req;
  rob_expt_pkg::cmplt_req_t  pipe4_req;
  logic [4:0]                write_sel;
  logic                      expt_cmplt;
  rob_expt_pkg::cmplt_info_t entry_updt;
  rob_expt_pkg::cmplt_info_t entry_info;
  logic                      split_spec_fail_flush;

  assign pipe0_req = pipe0_cmplt & PIPE0_KEEP;
  assign pipe2_req = pipe2_cmplt & PIPE2_KEEP;
  assign pipe3_req = pipe3_cmplt & LSU_KEEP;
  assign pipe4_req = pipe4_cmplt & LSU_KEEP;

  assign expt_entry_iid = entry_info.iid;

  expt_oldest_select expt_oldest_select_i (
    .pipe0      (pipe0_req),
    .pipe2      (pipe2_req),
    .pipe3      (pipe3_req),
    .pipe4      (pipe4_req),
    .entry_vld  (expt_entry_vld),
    .entry_iid  (entry_info.iid),
    .write_sel  (write_sel),
    .entry_updt (entry_updt),
    .expt_cmplt (expt_cmplt)
  );

  expt_entry expt_entry_i (
    .entry_clk             (entry_clk),
    .cpurst_b              (cpurst_b),
    .flush                 (flush),
    .expt_cmplt            (expt_cmplt),
    .write_sel             (write_sel),
    .entry_updt            (entry_updt),
    .retire_vld            (retire_vld),
    .retire_abnormal       (retire_abnormal),
    .split_spec_fail_flush (split_spec_fail_flush),
    .entry_vld             (expt_entry_vld),
    .entry_info            (entry_info),
    .retire_info           (retire_info)
  );

  ssf_tracker ssf_tracker_i (
    .entry_clk             (entry_clk),
    .cpurst_b              (cpurst_b),
    .flush                 (flush),
    .pipe3_ssf             (pipe3_ssf),
    .pipe4_ssf             (pipe4_ssf),
    .retire_vld            (retire_vld),
    .retire_iid            (retire_iid),
    .retire_split          (retire_split),
    .state                 (ssf_state),
    .ssf_iid               (ssf_iid),
    .srt                   (split_spec_fail_srt),
    .split_spec_fail_flush (split_spec_fail_flush)
  );

endmodule

`default_nettype wire

// ==== hdl/ssf_tracker.sv ====
// Split load/store speculation fail FSM; tracks oldest failing split iid and flushes after it retires
`timescale 1ns/1ns
`default_nettype none

`include "rob_expt_cfg.svh"

module ssf_tracker (
  input  logic                     entry_clk,
  input  logic                     cpurst_b,
  input  logic                     flush,
  input  rob_expt_pkg::ssf_req_t   pipe3_ssf,
  input  rob_expt_pkg::ssf_req_t   pipe4_ssf,
  input  logic                     retire_vld,
  input  logic [`ROB_IID_W-1:0]    retire_iid,
  input  logic                     retire_split,
  output rob_expt_pkg::ssf_state_t state,
  output logic [`ROB_IID_W-1:0]    ssf_iid,
  output logic                     srt,
  output logic                     split_spec_fail_flush
);

  logic sm_start;
  logic ssf_inst_retire;
  logic retire_no_split;
  logic held_vld;
  logic p4_older_p3;
  logic p4_older_held;
  logic p3_older_held;
  logic p4_take;
  logic p3_take;
  logic held_take;
  rob_expt_pkg::ssf_state_t state_nxt;

  assign sm_start        = pipe3_ssf.valid || pipe4_ssf.valid;
  assign ssf_inst_retire = retire_vld && (retire_iid == ssf_iid);
  assign retire_no_split = retire_vld && !retire_split;
  assign held_vld        = (state != rob_expt_pkg::IDLE);

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  // IDLE       nothing pending
  // WF_RETIRE  waiting for the failed split inst to retire
  // RETIRING   failed split inst retiring, flush at next non-split retire
  always_comb
  begin
    case (state)
      rob_expt_pkg::IDLE:
        state_nxt = sm_start ? rob_expt_pkg::WF_RETIRE : rob_expt_pkg::IDLE;
      rob_expt_pkg::WF_RETIRE:
        state_nxt = ssf_inst_retire ? rob_expt_pkg::RETIRING : rob_expt_pkg::WF_RETIRE;
      rob_expt_pkg::RETIRING:
        state_nxt = retire_no_split ? rob_expt_pkg::IDLE : rob_expt_pkg::RETIRING;
      default:
        state_nxt = rob_expt_pkg::IDLE;
    endcase
  end

  always_ff @(posedge entry_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state <= rob_expt_pkg::IDLE;
    else if (flush)
      state <= rob_expt_pkg::IDLE;
    else
      state <= state_nxt;
  end

  // Hold retire while anything is pending
  assign srt = state[1];
  assign split_spec_fail_flush = state[0] && retire_no_split;

  // --------------------------------------------------------------------------
  // Oldest failing iid
  // --------------------------------------------------------------------------
  assign p4_older_p3   = rob_expt_pkg::iid_older(pipe4_ssf.iid, pipe3_ssf.iid);
  assign p4_older_held = rob_expt_pkg::iid_older(pipe4_ssf.iid, ssf_iid);
  assign p3_older_held = rob_expt_pkg::iid_older(pipe3_ssf.iid, ssf_iid);

  // held iid only competes once the FSM left IDLE
  assign p4_take   = pipe4_ssf.valid && (!pipe3_ssf.valid || p4_older_p3)
                     && (!held_vld || p4_older_held);
  assign p3_take   = pipe3_ssf.valid && (!pipe4_ssf.valid || !p4_older_p3)
                     && (!held_vld || p3_older_held);
  assign held_take = held_vld && (!pipe4_ssf.valid || !p4_older_held)
                     && (!pipe3_ssf.valid || !p3_older_held);

  // Rewritten every cycle, zero when nothing selected
  always_ff @(posedge entry_clk)
  begin
    ssf_iid <= ({`ROB_IID_W{p4_take}} & pipe4_ssf.iid)
               | ({`ROB_IID_W{p3_take}} & pipe3_ssf.iid)
               | ({`ROB_IID_W{held_take}} & ssf_iid);
  end

endmodule

`default_nettype wire

// ==== rob_expt_top.f ====
+incdir+common
common/rob_expt_pkg.sv
hdl/expt_oldest_select.sv
hdl/expt_entry.sv
hdl/ssf_tracker.sv
hdl/rob_expt_top.sv
verification/rob_expt_checker.sv
verification/rob_expt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ROB exception block simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rob_expt_top.f --top-module rob_expt_tb \
  -Mdir obj_dir > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/Vrob_expt_tb > sim.log 2>&1 || echo "Simulator returned non-zero"

grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// ==== verification/rob_expt_checker.sv ====
// Concurrent assertions on the ROB exception block, bound into rob_expt_top by the testbench
`timescale 1ns/1ns
`default_nettype none

module rob_expt_checker (
  input  logic       entry_clk,
  input  logic       cpurst_b,
  input  logic       flush,
  input  logic       expt_cmplt,
  input  logic [4:0] write_sel,
  input  logic       split_spec_fail_srt,
  input  logic [1:0] ssf_state,
  input  logic       expt_entry_vld
);

  // Exactly one winner whenever a pipe completes abnormally
  write_sel_onehot: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    expt_cmplt |-> $onehot(write_sel))
    else $error("write_sel is not one-hot on an abnormal completion");

  // No way back to idle from the wait state except flush
  srt_held_in_wait: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    split_spec_fail_srt && !ssf_state[0] && !flush |=> split_spec_fail_srt && ssf_state[1])
    else $error("srt dropped while waiting for the split instruction to retire");

  // Flush empties the entry on the next edge
  flush_clears_entry: assert property (@(posedge entry_clk) disable iff (!cpurst_b)
    flush |=> !expt_entry_vld)
    else $error("expt_entry_vld still set one cycle after flush");

endmodule

`default_nettype wire

// ==== verification/rob_expt_tb.sv ====
// Self-checking testbench for rob_expt_top; drives pipes, retire slot and flush against a model
`timescale 1ns/1ns
`default_nettype none

`include "rob_expt_cfg.svh"

module rob_expt_tb;

  localparam int IW             = `ROB_IID_W;
  localparam int TIMEOUT_CYCLES = 400;

  logic                       entry_clk;
  logic                       cpurst_b;
  rob_expt_pkg::cmplt_req_t   pipe0_cmplt;
  rob_expt_pkg::cmplt_req_t   pipe2_cmplt;
  rob_expt_pkg::cmplt_req_t   pipe3_cmplt;
  rob_expt_pkg::cmplt_req_t   pipe4_cmplt;
  rob_expt_pkg::ssf_req_t     pipe3_ssf;
  rob_expt_pkg::ssf_req_t     pipe4_ssf;
  logic                       retire_vld;
  logic                       retire_abnormal;
  logic [IW-1:0]              retire_iid;
  logic                       retire_split;
  logic                       flush;
  rob_expt_pkg::retire_info_t retire_info;
  logic                       expt_entry_vld;
  logic [IW-1:0]              expt_entry_iid;
  logic                       split_spec_fail_srt;
  logic [IW-1:0]              ssf_iid;
  rob_expt_pkg::ssf_state_t   ssf_state;

  // Model state
  logic                       m_vld;
  logic                       m_info_known;
  rob_expt_pkg::cmplt_info_t  m_info;
  rob_expt_pkg::ssf_state_t   m_state;
  logic [IW-1:0]              m_ssf_iid;

  int err_cnt;
  int chk_cnt;
  int cycle_cnt;

  rob_expt_top rob_expt_top_i (.*);

  bind rob_expt_top rob_expt_checker rob_expt_checker_i (
    .entry_clk           (entry_clk),
    .cpurst_b            (cpurst_b),
    .flush               (flush),
    .expt_cmplt          (expt_cmplt),
    .write_sel           (write_sel),
    .split_spec_fail_srt (split_spec_fail_srt),
    .ssf_state           (ssf_state),
    .expt_entry_vld      (expt_entry_vld)
  );

  initial
  begin
    entry_clk = 1'b0;
  end

  always #50 entry_clk = ~entry_clk;

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  // Wrap-aware age, a older than b
  function automatic logic older(input logic [IW-1:0] a, input logic [IW-1:0] b);
    if (a[IW-1] == b[IW-1])
      return a[IW-2:0] < b[IW-2:0];
    return a[IW-2:0] > b[IW-2:0];
  endfunction

  // Fields each pipe really carries
  function automatic rob_expt_pkg::cmplt_info_t trim(input int pnum,
                                                     input rob_expt_pkg::cmplt_info_t i);
    rob_expt_pkg::cmplt_info_t t;
    t = '0;
    t.iid = i.iid;
    if (pnum == 0)
    begin
      t.expt_vld      = i.expt_vld;
      t.expt_vec[4:0] = i.expt_vec[4:0];
      t.mtval[31:0]   = i.mtval[31:0];
      t.flush         = i.flush;
      t.bkpt          = i.bkpt;
    end
    else if (pnum == 2)
    begin
      t.jmp_mispred = i.jmp_mispred;
      t.bht_mispred = i.bht_mispred;
    end
    else
    begin
      t.expt_vld  = i.expt_vld;
      t.expt_vec  = i.expt_vec;
      t.mtval     = i.mtval;
      t.flush     = i.flush;
      t.spec_fail = i.spec_fail;
    end
    return t;
  endfunction

  // Expected retire slot view
  function automatic rob_expt_pkg::retire_info_t ref_retire(
    input rob_expt_pkg::cmplt_info_t info, input logic abn, input logic ssf_flush);
    rob_expt_pkg::retire_info_t r;
    r.expt_vld         = abn && info.expt_vld;
    r.expt_vec         = info.expt_vec;
    r.mtval            = info.mtval;
    r.jmp_mispred      = abn && info.jmp_mispred;
    r.bht_mispred      = abn && info.bht_mispred;
    r.bkpt             = abn && info.bkpt;
    r.inst_flush       = (abn && !info.expt_vld && info.flush) || (!abn && ssf_flush);
    r.spec_fail_ssf    = !abn && ssf_flush;
    r.spec_fail_no_ssf = abn && info.spec_fail;
    r.spec_fail        = r.spec_fail_ssf || r.spec_fail_no_ssf;
    return r;
  endfunction

  // Advance the model by one edge from the inputs now applied
  task automatic update_model();
    rob_expt_pkg::cmplt_req_t  p[4];
    int                        pnum[4];
    logic                      best_ok;
    logic [IW-1:0]             best_iid;
    logic                      any;
    logic                      ssf_go;
    rob_expt_pkg::ssf_state_t  nxt;
    p[0] = pipe0_cmplt;
    p[1] = pipe2_cmplt;
    p[2] = pipe3_cmplt;
    p[3] = pipe4_cmplt;
    pnum = '{0, 2, 3, 4};
    best_ok  = m_vld;
    best_iid = m_info.iid;
    any      = 1'b0;
    for (int k = 0; k < 4; k++)
    begin
      if (p[k].cmplt && p[k].abnormal)
      begin
        any = 1'b1;
        if (!best_ok || older(p[k].info.iid, best_iid))
        begin
          best_ok      = 1'b1;
          best_iid     = p[k].info.iid;
          m_info       = trim(pnum[k], p[k].info);
          m_info_known = 1'b1;
        end
      end
    end
    if (flush)
      m_vld = 1'b0;
    else if (any)
      m_vld = 1'b1;
    else if (retire_vld && retire_abnormal)
      m_vld = 1'b0;
    // Tracker next state
    ssf_go = pipe3_ssf.valid || pipe4_ssf.valid;
    nxt = m_state;
    if (m_state == rob_expt_pkg::IDLE && ssf_go)
      nxt = rob_expt_pkg::WF_RETIRE;
    else if (m_state == rob_expt_pkg::WF_RETIRE && retire_vld && retire_iid == m_ssf_iid)
      nxt = rob_expt_pkg::RETIRING;
    else if (m_state == rob_expt_pkg::RETIRING && retire_vld && !retire_split)
      nxt = rob_expt_pkg::IDLE;
    // Tracker iid, held value competes only when pending
    best_ok  = (m_state != rob_expt_pkg::IDLE);
    best_iid = m_ssf_iid;
    if (pipe4_ssf.valid && (!best_ok || older(pipe4_ssf.iid, best_iid)))
    begin
      best_ok  = 1'b1;
      best_iid = pipe4_ssf.iid;
    end
    if (pipe3_ssf.valid && (!best_ok || older(pipe3_ssf.iid, best_iid)))
    begin
      best_ok  = 1'b1;
      best_iid = pipe3_ssf.iid;
    end
    m_ssf_iid = best_ok ? best_iid : '0;
    m_state   = flush ? rob_expt_pkg::IDLE : nxt;
  endtask

  // --------------------------------------------------------------------------
  // Checking
  // --------------------------------------------------------------------------
  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp)
    begin
      err_cnt++;
      $display("[ERROR] %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic compare_outputs();
    rob_expt_pkg::retire_info_t exp;
    logic                       ssf_flush;
    ssf_flush = (m_state == rob_expt_pkg::RETIRING) && retire_vld && !retire_split;
    exp = ref_retire(m_info, retire_abnormal, ssf_flush);
    check("expt_vld", 64'(retire_info.expt_vld), 64'(exp.expt_vld));
    check("jmp_mispred", 64'(retire_info.jmp_mispred), 64'(exp.jmp_mispred));
    check("bht_mispred", 64'(retire_info.bht_mispred), 64'(exp.bht_mispred));
    check("bkpt", 64'(retire_info.bkpt), 64'(exp.bkpt));
    check("inst_flush", 64'(retire_info.inst_flush), 64'(exp.inst_flush));
    check("spec_fail", 64'(retire_info.spec_fail), 64'(exp.spec_fail));
    check("spec_fail_ssf", 64'(retire_info.spec_fail_ssf), 64'(exp.spec_fail_ssf));
    check("spec_fail_no_ssf", 64'(retire_info.spec_fail_no_ssf), 64'(exp.spec_fail_no_ssf));
    if (m_info_known && retire_abnormal)
    begin
      check("expt_vec", 64'(retire_info.expt_vec), 64'(exp.expt_vec));
      check("mtval", retire_info.mtval, exp.mtval);
    end
    check("expt_entry_vld", 64'(expt_entry_vld), 64'(m_vld));
    if (m_vld)
      check("expt_entry_iid", 64'(expt_entry_iid), 64'(m_info.iid));
    check("split_spec_fail_srt", 64'(split_spec_fail_srt), 64'(m_state[1]));
    check("ssf_state", 64'(ssf_state), 64'(m_state));
    if (m_state != rob_expt_pkg::IDLE)
      check("ssf_iid", 64'(ssf_iid), 64'(m_ssf_iid));
  endtask

  // Sample just before each edge, then step the model
  always
  begin
    @(posedge entry_clk);
    #90;
    if (!cpurst_b)
    begin
      m_vld        = 1'b0;
      m_info_known = 1'b0;
      m_info       = '0;
      m_state      = rob_expt_pkg::IDLE;
      m_ssf_iid    = '0;
    end
    else
    begin
      compare_outputs();
      update_model();
    end
  end

  // Stimulus needs well under 200 cycles
  always @(posedge entry_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, stimulus did not finish", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic clear_inputs();
    pipe0_cmplt     = '0;
    pipe2_cmplt     = '0;
    pipe3_cmplt     = '0;
    pipe4_cmplt     = '0;
    pipe3_ssf       = '0;
    pipe4_ssf       = '0;
    retire_vld      = 1'b0;
    retire_abnormal = 1'b0;
    retire_iid      = '0;
    retire_split    = 1'b0;
    flush           = 1'b0;
  endtask

  // Next drive point, 10 ns after the edge
  task automatic step();
    @(posedge entry_clk);
    #10;
    clear_inputs();
  endtask

  function automatic rob_expt_pkg::cmplt_info_t rand_info(input logic [IW-1:0] iid);
    rob_expt_pkg::cmplt_info_t i;
    logic [31:0]               r;
    r             = $urandom;
    i.iid         = iid;
    i.expt_vld    = 1'b1;
    i.expt_vec    = r[13:0];
    i.flush       = r[14];
    i.spec_fail   = r[15];
    i.bkpt        = r[16];
    i.jmp_mispred = r[17];
    i.bht_mispred = r[18];
    i.mtval       = {32'($urandom), 32'($urandom)};
    return i;
  endfunction

  task automatic drive_pipe(input int pnum, input rob_expt_pkg::cmplt_info_t info);
    rob_expt_pkg::cmplt_req_t req;
    req.cmplt    = 1'b1;
    req.abnormal = 1'b1;
    req.info     = info;
    case (pnum)
      0: pipe0_cmplt = req;
      2: pipe2_cmplt = req;
      3: pipe3_cmplt = req;
      default: pipe4_cmplt = req;
    endcase
  endtask

  task automatic retire_abn(input logic [IW-1:0] iid);
    retire_vld      = 1'b1;
    retire_abnormal = 1'b1;
    retire_iid      = iid;
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    logic [IW-1:0]             base;
    logic [31:0]               r;
    logic [3:0]                mask;
    rob_expt_pkg::cmplt_info_t info;
    int                        pn[4];
    err_cnt   = 0;
    chk_cnt   = 0;
    cycle_cnt = 0;
    void'($urandom(94795));
    pn        = '{0, 2, 3, 4};
    cpurst_b  = 1'b0;
    clear_inputs();
    repeat (5) @(posedge entry_clk);
    #10;
    cpurst_b = 1'b1;
    step();
    step();

    // Single exceptions on pipe0 and pipe3
    for (int k = 0; k < 2; k++)
    begin
      r = $urandom;
      drive_pipe(k == 0 ? 0 : 3, rand_info(r[IW-1:0]));
      step();
      step();
      retire_abn(r[IW-1:0]);
      step();
      step();
    end

    // Several pipes at once, iids within one ROB window around the wrap
    for (int n = 0; n < 20; n++)
    begin
      r    = $urandom;
      base = (n < 4) ? 7'(7'h3c + 7'(n * 32)) : r[IW-1:0];
      mask = r[11:8];
      if ($countones(mask) < 2)
        mask = mask | 4'b0101;
      for (int k = 0; k < 4; k++)
      begin
        r = $urandom;
        if (mask[k])
          drive_pipe(pn[k], rand_info(base + 7'({r[2:0], 2'(k)})));
      end
      step();
      drive_pipe(3, rand_info(base + 7'd40));
      step();
      step();
      retire_abn(base);
      step();
    end

    // Mispredicts and flush-only completion
    info = rand_info(7'h11);
    info.jmp_mispred = 1'b1;
    info.bht_mispred = 1'b0;
    drive_pipe(2, info);
    step();
    retire_abn(7'h11);
    step();
    info = rand_info(7'h12);
    info.expt_vld = 1'b0;
    info.flush    = 1'b1;
    drive_pipe(3, info);
    step();
    retire_abn(7'h12);
    step();

    // Split spec fail sequence
    pipe4_ssf = '{valid: 1'b1, iid: 7'h7a};
    step();
    step();
    pipe3_ssf = '{valid: 1'b1, iid: 7'h74};
    step();
    retire_vld   = 1'b1;
    retire_iid   = 7'h74;
    retire_split = 1'b1;
    step();
    step();
    retire_vld = 1'b1;
    retire_iid = 7'h75;
    step();
    step();

    // Flush with the entry valid and the tracker in each busy state
    for (int k = 0; k < 2; k++)
    begin
      drive_pipe(0, rand_info(7'h20));
      pipe3_ssf = '{valid: 1'b1, iid: 7'h21};
      step();
      if (k == 1)
      begin
        retire_vld = 1'b1;
        retire_iid = 7'h21;
        step();
      end
      flush = 1'b1;
      step();
      step();
    end
    step();

    $display("Errors: %0d in %0d checks", err_cnt, chk_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
